/* logic/radio_ctrl_pkg.sv */
package radio_ctrl_pkg;

  // Host command bus
  localparam int CMD_ADDR_W = 6;
  localparam int CMD_DATA_W = 32;

  // Response word returned to the host
  localparam int RESP_W = 40;

  // Telemetry values from the slow ADC
  localparam int TELEM_W = 12;

  // Command addresses decoded by this block
  typedef enum logic [CMD_ADDR_W-1:0] {
    CMD_GENERAL = 6'd0,   // bit 12 disables the supply sync clocks
    CMD_TX_CFG  = 6'd9,   // vna, pa_enable, tr_disable
    CMD_CW_HANG = 6'd16   // 10-bit CW hang time
  } cmd_addr_e;

  // LED flasher states
  typedef enum logic [1:0] {
    LED_CLR,
    LED_SET,
    LED_WAIT1,
    LED_WAIT2
  } led_state_e;

  // Response machine, one echo deep
  typedef enum logic {
    RESP_IDLE,
    RESP_PENDING
  } resp_state_e;

  // Rotating status slots
  typedef enum logic [1:0] {
    SLOT_ID,
    SLOT_FWD_TEMP,
    SLOT_REV_BIAS,
    SLOT_SPARE
  } resp_slot_e;

endpackage

/* logic/tick_timer.sv */
`timescale 1ns/1ps

module tick_timer #(
  parameter int CLKS_PER_MS   = 2500,
  parameter int LED_TICK_BITS = 6
) (
  input  logic clk,
  input  logic reset_i,
  output logic ms_tick_o,
  output logic led_tick_o
);

  localparam int CNT_W = (CLKS_PER_MS > 1) ? $clog2(CLKS_PER_MS) : 1;

  logic [CNT_W-1:0]         clk_cnt_q;
  logic [LED_TICK_BITS-1:0] ms_cnt_q;

  // One-cycle pulse on the last clock of each millisecond
  assign ms_tick_o = (clk_cnt_q == CNT_W'(CLKS_PER_MS - 1));

  // LED tick once every 2**LED_TICK_BITS milliseconds
  assign led_tick_o = ms_tick_o & (&ms_cnt_q);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      clk_cnt_q <= '0;
      ms_cnt_q  <= '0;
    end else if (ms_tick_o) begin
      clk_cnt_q <= '0;
      ms_cnt_q  <= ms_cnt_q + LED_TICK_BITS'(1);
    end else begin
      clk_cnt_q <= clk_cnt_q + CNT_W'(1);
    end
  end

endmodule

/* logic/led_flash.sv */
`timescale 1ns/1ps

module led_flash (
  input  logic clk,
  input  logic reset_i,
  input  logic led_tick_i,
  input  logic event_i,
  output logic led_o
);

  import radio_ctrl_pkg::*;

  led_state_e state_q;
  led_state_e state_d;

  // Catch the event, then hold for three LED ticks
  always_comb begin
    state_d = state_q;
    case (state_q)
      LED_CLR: begin
        if (event_i) begin
          state_d = LED_SET;
        end
      end
      LED_SET: begin
        if (led_tick_i) begin
          state_d = LED_WAIT1;
        end
      end
      LED_WAIT1: begin
        if (led_tick_i) begin
          state_d = LED_WAIT2;
        end
      end
      default: begin
        if (led_tick_i) begin
          state_d = LED_CLR;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= LED_CLR;
    end else begin
      state_q <= state_d;
    end
  end

  // Active low, dark only while idle
  assign led_o = (state_q == LED_CLR);

endmodule

/* logic/cmd_regs.sv */
`timescale 1ns/1ps

module cmd_regs (
  input  logic                              clk,
  input  logic                              reset_i,
  input  logic                              cmd_rqst_i,
  input  logic [radio_ctrl_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [radio_ctrl_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                              cmd_ptt_i,
  output logic                              int_ptt_o,
  output logic                              vna_o,
  output logic                              pa_enable_o,
  output logic                              tr_disable_o,
  output logic                              disable_syncfreq_o,
  output logic [9:0]                        cw_hang_time_o
);

  import radio_ctrl_pkg::*;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      int_ptt_o          <= 1'b0;
      vna_o              <= 1'b0;
      pa_enable_o        <= 1'b0;
      tr_disable_o       <= 1'b0;
      disable_syncfreq_o <= 1'b0;
      cw_hang_time_o     <= '0;
    end else if (cmd_rqst_i) begin
      // PTT rides along with every command
      int_ptt_o <= cmd_ptt_i;
      case (cmd_addr_i)
        CMD_GENERAL: begin
          disable_syncfreq_o <= cmd_data_i[12];
        end
        CMD_TX_CFG: begin
          vna_o        <= cmd_data_i[23];
          pa_enable_o  <= cmd_data_i[19];
          tr_disable_o <= cmd_data_i[18];
        end
        CMD_CW_HANG: begin
          // Hang time is split across two fields
          cw_hang_time_o <= {cmd_data_i[31:24], cmd_data_i[17:16]};
        end
        default: begin
          // Addresses owned by other blocks
        end
      endcase
    end
  end

endmodule

/* logic/tx_keying.sv */
`timescale 1ns/1ps

module tx_keying (
  input  logic int_ptt_i,
  input  logic cw_key_i,
  input  logic ptt_key_i,
  input  logic tx_hang_i,
  input  logic txinhibit_i,
  input  logic run_i,
  input  logic vna_i,
  input  logic pa_enable_i,
  input  logic tr_disable_i,
  output logic tx_on_o,
  output logic pa_tr_o,
  output logic pa_en_o,
  output logic rfsw_sel_o
);

  logic key_req;
  logic pa_path;

  // Any key source, gated by inhibit and host run
  assign key_req = int_ptt_i | cw_key_i | ptt_key_i | tx_hang_i;
  assign tx_on_o = key_req & ~txinhibit_i & run_i;

  // Amplifier path usable only outside VNA mode
  assign pa_path = ~vna_i & pa_enable_i;

  // T/R relay also switches when the PA is bypassed, unless disabled
  assign pa_tr_o = tx_on_o & ~vna_i & (pa_enable_i | ~tr_disable_i);

  assign pa_en_o    = tx_on_o & pa_path;
  assign rfsw_sel_o = pa_path;

endmodule

/* logic/resp_fsm.sv */
`timescale 1ns/1ps

module resp_fsm #(
  parameter logic [7:0] SERIAL_NO = 8'h00
) (
  input  logic                                  clk,
  input  logic                                  reset_i,
  input  logic                                  cmd_rqst_i,
  input  logic                                  cmd_requires_resp_i,
  input  logic [radio_ctrl_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [radio_ctrl_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                                  resp_rqst_i,
  input  logic                                  tx_on_i,
  input  logic                                  cw_key_i,
  input  logic                                  ptt_key_i,
  input  logic                                  rxclip_i,
  input  logic [radio_ctrl_pkg::TELEM_W-1:0]    fwd_pwr_i,
  input  logic [radio_ctrl_pkg::TELEM_W-1:0]    rev_pwr_i,
  input  logic [radio_ctrl_pkg::TELEM_W-1:0]    temperature_i,
  input  logic [radio_ctrl_pkg::TELEM_W-1:0]    bias_current_i,
  output logic [radio_ctrl_pkg::RESP_W-1:0]     resp_o
);

  import radio_ctrl_pkg::*;

  resp_state_e           state_q;
  resp_slot_e            slot_q;
  logic [CMD_ADDR_W-1:0] echo_addr_q;
  logic [CMD_DATA_W-1:0] echo_data_q;
  logic [1:0]            clip_cnt_q;
  logic                  clip_flag;
  logic                  capture;
  logic [7:0]            slot_hdr;
  logic [CMD_DATA_W-1:0] slot_body;

  assign clip_flag = &clip_cnt_q;

  // Queue is one deep; a pending echo is only replaced on a read
  assign capture = cmd_rqst_i & cmd_requires_resp_i &
                   ((state_q == RESP_IDLE) | resp_rqst_i);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= RESP_IDLE;
    end else if (capture) begin
      state_q <= RESP_PENDING;
    end else if (resp_rqst_i) begin
      state_q <= RESP_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      echo_addr_q <= cmd_addr_i;
      echo_data_q <= cmd_data_i;
    end
  end

  // Status slot contents
  always_comb begin
    slot_hdr = {3'b000, slot_q, 1'b0, cw_key_i, ptt_key_i};
    case (slot_q)
      SLOT_ID:       slot_body = {7'b0001111, clip_flag, 16'h0000, SERIAL_NO};
      SLOT_FWD_TEMP: slot_body = {16'(temperature_i), 16'(fwd_pwr_i)};
      SLOT_REV_BIAS: slot_body = {16'(rev_pwr_i), 16'(bias_current_i)};
      default:       slot_body = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      resp_o     <= {8'h00, 7'b0001111, 1'b0, 16'h0000, SERIAL_NO};
      slot_q     <= SLOT_ID;
      clip_cnt_q <= 2'b00;
    end else if (resp_rqst_i) begin
      // Slot advances even when an echo takes its place
      slot_q     <= resp_slot_e'(slot_q + 2'd1);
      clip_cnt_q <= 2'b00;
      if (state_q == RESP_PENDING) begin
        resp_o <= {1'b1, echo_addr_q, tx_on_i, echo_data_q};
      end else begin
        resp_o <= {slot_hdr, slot_body};
      end
    end else if (!clip_flag) begin
      clip_cnt_q <= clip_cnt_q + {1'b0, rxclip_i};
    end
  end

endmodule

/* logic/radio_ctrl_top.sv */
`timescale 1ns/1ps

module radio_ctrl_top #(
  parameter int         CLKS_PER_MS   = 2500,
  parameter int         LED_TICK_BITS = 6,
  parameter logic [7:0] SERIAL_NO     = 8'h00
) (
  input  logic                                  clk,
  input  logic                                  reset_i,
  input  logic                                  cmd_rqst_i,
  input  logic [radio_ctrl_pkg::CMD_ADDR_W-1:0] cmd_addr_i,
  input  logic [radio_ctrl_pkg::CMD_DATA_W-1:0] cmd_data_i,
  input  logic                                  cmd_ptt_i,
  input  logic                                  cmd_requires_resp_i,
  input  logic                                  resp_rqst_i,
  input  logic                                  cw_key_i,
  input  logic                                  ptt_key_i,
  input  logic                                  tx_hang_i,
  input  logic                                  txinhibit_i,
  input  logic                                  run_i,
  input  logic                                  rxgoodlvl_i,
  input  logic                                  rxclip_i,
  input  logic [radio_ctrl_pkg::TELEM_W-1:0]    fwd_pwr_i,
  input  logic [radio_ctrl_pkg::TELEM_W-1:0]    rev_pwr_i,
  input  logic [radio_ctrl_pkg::TELEM_W-1:0]    temperature_i,
  input  logic [radio_ctrl_pkg::TELEM_W-1:0]    bias_current_i,
  output logic                                  tx_on_o,
  output logic                                  pa_tr_o,
  output logic                                  pa_en_o,
  output logic                                  rfsw_sel_o,
  output logic                                  led_goodlvl_o,
  output logic                                  led_clip_o,
  output logic [radio_ctrl_pkg::RESP_W-1:0]     resp_o,
  output logic                                  disable_syncfreq_o,
  output logic [9:0]                            cw_hang_time_o
);

  logic led_tick;
  logic int_ptt;
  logic vna;
  logic pa_enable;
  logic tr_disable;

  tick_timer #(
    .CLKS_PER_MS   (CLKS_PER_MS),
    .LED_TICK_BITS (LED_TICK_BITS)
  ) u_tick_timer (
    .clk        (clk),
    .reset_i    (reset_i),
    .ms_tick_o  (),
    .led_tick_o (led_tick)
  );

  // Receiver status LEDs
  led_flash u_led_goodlvl (
    .clk        (clk),
    .reset_i    (reset_i),
    .led_tick_i (led_tick),
    .event_i    (rxgoodlvl_i),
    .led_o      (led_goodlvl_o)
  );

  led_flash u_led_clip (
    .clk        (clk),
    .reset_i    (reset_i),
    .led_tick_i (led_tick),
    .event_i    (rxclip_i),
    .led_o      (led_clip_o)
  );

  cmd_regs u_cmd_regs (
    .clk                (clk),
    .reset_i            (reset_i),
    .cmd_rqst_i         (cmd_rqst_i),
    .cmd_addr_i         (cmd_addr_i),
    .cmd_data_i         (cmd_data_i),
    .cmd_ptt_i          (cmd_ptt_i),
    .int_ptt_o          (int_ptt),
    .vna_o              (vna),
    .pa_enable_o        (pa_enable),
    .tr_disable_o       (tr_disable),
    .disable_syncfreq_o (disable_syncfreq_o),
    .cw_hang_time_o     (cw_hang_time_o)
  );

  tx_keying u_tx_keying (
    .int_ptt_i    (int_ptt),
    .cw_key_i     (cw_key_i),
    .ptt_key_i    (ptt_key_i),
    .tx_hang_i    (tx_hang_i),
    .txinhibit_i  (txinhibit_i),
    .run_i        (run_i),
    .vna_i        (vna),
    .pa_enable_i  (pa_enable),
    .tr_disable_i (tr_disable),
    .tx_on_o      (tx_on_o),
    .pa_tr_o      (pa_tr_o),
    .pa_en_o      (pa_en_o),
    .rfsw_sel_o   (rfsw_sel_o)
  );

  resp_fsm #(
    .SERIAL_NO (SERIAL_NO)
  ) u_resp_fsm (
    .clk                 (clk),
    .reset_i             (reset_i),
    .cmd_rqst_i          (cmd_rqst_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_data_i          (cmd_data_i),
    .resp_rqst_i         (resp_rqst_i),
    .tx_on_i             (tx_on_o),
    .cw_key_i            (cw_key_i),
    .ptt_key_i           (ptt_key_i),
    .rxclip_i            (rxclip_i),
    .fwd_pwr_i           (fwd_pwr_i),
    .rev_pwr_i           (rev_pwr_i),
    .temperature_i       (temperature_i),
    .bias_current_i      (bias_current_i),
    .resp_o              (resp_o)
  );

endmodule

/* testbench/radio_ctrl_props.sv */
`timescale 1ns/1ps

module radio_ctrl_props (
  input logic                              clk,
  input logic                              reset_i,
  input logic                              int_ptt_i,
  input logic                              cw_key_i,
  input logic                              ptt_key_i,
  input logic                              tx_hang_i,
  input logic                              txinhibit_i,
  input logic                              run_i,
  input logic                              vna_i,
  input logic                              pa_enable_i,
  input logic                              tr_disable_i,
  input logic                              tx_on_i,
  input logic                              pa_tr_i,
  input logic                              pa_en_i,
  input logic                              rxclip_i,
  input logic                              rxgoodlvl_i,
  input logic                              led_clip_i,
  input logic                              led_goodlvl_i,
  input logic                              resp_rqst_i,
  input logic [radio_ctrl_pkg::RESP_W-1:0] resp_i
);

  // Length of the current low phase of each LED
  logic [7:0] clip_low_q;
  logic [7:0] good_low_q;

  // Running count of failed assertions
  int fail_cnt = 0;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      clip_low_q <= '0;
      good_low_q <= '0;
    end else begin
      clip_low_q <= led_clip_i ? 8'd0 : clip_low_q + 8'd1;
      good_low_q <= led_goodlvl_i ? 8'd0 : good_low_q + 8'd1;
    end
  end

  keying: assert property (@(posedge clk) disable iff (reset_i)
    tx_on_i == ((int_ptt_i | cw_key_i | ptt_key_i | tx_hang_i) & ~txinhibit_i & run_i))
    else begin
      fail_cnt++;
      $error("tx_on_o does not follow the keying inputs");
    end

  pa_lines: assert property (@(posedge clk) disable iff (reset_i)
    pa_tr_i == (tx_on_i & ~vna_i & (pa_enable_i | ~tr_disable_i)) &&
    pa_en_i == (tx_on_i & ~vna_i & pa_enable_i))
    else begin
      fail_cnt++;
      $error("pa_tr_o or pa_en_o does not follow the amplifier rule");
    end

  // Clip LED, 32 clocks per LED tick here
  clip_start: assert property (@(posedge clk) disable iff (reset_i)
    (led_clip_i && rxclip_i) |=> !led_clip_i)
    else begin
      fail_cnt++;
      $error("clip LED did not light after a clip event");
    end
  clip_cause: assert property (@(posedge clk) disable iff (reset_i)
    $fell(led_clip_i) |-> $past(rxclip_i))
    else begin
      fail_cnt++;
      $error("clip LED lit without a clip event");
    end
  clip_min: assert property (@(posedge clk) disable iff (reset_i)
    $rose(led_clip_i) |-> clip_low_q > 8'd64)
    else begin
      fail_cnt++;
      $error("clip LED flash shorter than two LED ticks");
    end
  clip_max: assert property (@(posedge clk) disable iff (reset_i)
    !led_clip_i |-> clip_low_q < 8'd96)
    else begin
      fail_cnt++;
      $error("clip LED flash longer than three LED ticks");
    end

  good_start: assert property (@(posedge clk) disable iff (reset_i)
    (led_goodlvl_i && rxgoodlvl_i) |=> !led_goodlvl_i)
    else begin
      fail_cnt++;
      $error("level LED did not light after a level event");
    end
  good_cause: assert property (@(posedge clk) disable iff (reset_i)
    $fell(led_goodlvl_i) |-> $past(rxgoodlvl_i))
    else begin
      fail_cnt++;
      $error("level LED lit without a level event");
    end
  good_min: assert property (@(posedge clk) disable iff (reset_i)
    $rose(led_goodlvl_i) |-> good_low_q > 8'd64)
    else begin
      fail_cnt++;
      $error("level LED flash shorter than two LED ticks");
    end
  good_max: assert property (@(posedge clk) disable iff (reset_i)
    !led_goodlvl_i |-> good_low_q < 8'd96)
    else begin
      fail_cnt++;
      $error("level LED flash longer than three LED ticks");
    end

  // Response only moves on a read, and slot headers keep their zero bits
  resp_hold: assert property (@(posedge clk) disable iff (reset_i)
    $changed(resp_i) |-> $past(resp_rqst_i))
    else begin
      fail_cnt++;
      $error("resp_o changed without a read strobe");
    end
  resp_slot: assert property (@(posedge clk) disable iff (reset_i)
    !resp_i[39] |-> (resp_i[38:37] == 2'b00 && !resp_i[34]))
    else begin
      fail_cnt++;
      $error("status slot header has a nonzero fixed bit");
    end

endmodule

bind radio_ctrl_top radio_ctrl_props u_props (
  .clk           (clk),
  .reset_i       (reset_i),
  .int_ptt_i     (int_ptt),
  .cw_key_i      (cw_key_i),
  .ptt_key_i     (ptt_key_i),
  .tx_hang_i     (tx_hang_i),
  .txinhibit_i   (txinhibit_i),
  .run_i         (run_i),
  .vna_i         (vna),
  .pa_enable_i   (pa_enable),
  .tr_disable_i  (tr_disable),
  .tx_on_i       (tx_on_o),
  .pa_tr_i       (pa_tr_o),
  .pa_en_i       (pa_en_o),
  .rxclip_i      (rxclip_i),
  .rxgoodlvl_i   (rxgoodlvl_i),
  .led_clip_i    (led_clip_o),
  .led_goodlvl_i (led_goodlvl_o),
  .resp_rqst_i   (resp_rqst_i),
  .resp_i        (resp_o)
);

/* testbench/radio_ctrl_tb.sv */
`timescale 1ns/1ps

module radio_ctrl_tb;

  import radio_ctrl_pkg::*;

  localparam int CLK_NS      = 40;
  localparam int STIM_CYCLES = 600;
  // One and a half times the planned stimulus
  localparam int WATCHDOG_NS = STIM_CYCLES * CLK_NS * 3 / 2;
  localparam logic [7:0] SERIAL = 8'h5A;

  logic                  clk;
  logic                  reset_i;
  logic                  cmd_rqst_i;
  logic [CMD_ADDR_W-1:0] cmd_addr_i;
  logic [CMD_DATA_W-1:0] cmd_data_i;
  logic                  cmd_ptt_i;
  logic                  cmd_requires_resp_i;
  logic                  resp_rqst_i;
  logic                  cw_key_i;
  logic                  ptt_key_i;
  logic                  tx_hang_i;
  logic                  txinhibit_i;
  logic                  run_i;
  logic                  rxgoodlvl_i;
  logic                  rxclip_i;
  logic [TELEM_W-1:0]    fwd_pwr_i;
  logic [TELEM_W-1:0]    rev_pwr_i;
  logic [TELEM_W-1:0]    temperature_i;
  logic [TELEM_W-1:0]    bias_current_i;
  logic                  tx_on_o;
  logic                  pa_tr_o;
  logic                  pa_en_o;
  logic                  rfsw_sel_o;
  logic                  led_goodlvl_o;
  logic                  led_clip_o;
  logic [RESP_W-1:0]     resp_o;
  logic                  disable_syncfreq_o;
  logic [9:0]            cw_hang_time_o;

  // Reference model of the host-visible state
  logic                  int_ptt_m;
  logic                  vna_m;
  logic                  pa_en_m;
  logic                  sync_dis_m;
  logic [9:0]            hang_m;
  logic [1:0]            slot_m;
  logic [1:0]            clip_m;
  logic                  pend_m;
  logic [CMD_ADDR_W-1:0] echo_addr_m;
  logic [CMD_DATA_W-1:0] echo_data_m;
  logic [15:0]           lfsr_q;
  int                    resp_errs;
  int                    cfg_errs;

  radio_ctrl_top #(
    .CLKS_PER_MS   (8),
    .LED_TICK_BITS (2),
    .SERIAL_NO     (SERIAL)
  ) uut (.*);

  always #20 clk = ~clk;

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // Echo or status slot, as the host should see it
  function automatic logic [RESP_W-1:0] expected_resp();
    logic        tx_on_m;
    logic [31:0] body;
    tx_on_m = (int_ptt_m | cw_key_i | ptt_key_i | tx_hang_i) & ~txinhibit_i & run_i;
    case (slot_m)
      2'd0:    body = {7'b0001111, clip_m == 2'd3, 16'h0000, SERIAL};
      2'd1:    body = {4'h0, temperature_i, 4'h0, fwd_pwr_i};
      2'd2:    body = {4'h0, rev_pwr_i, 4'h0, bias_current_i};
      default: body = '0;
    endcase
    if (pend_m) begin
      return {1'b1, echo_addr_m, tx_on_m, echo_data_m};
    end else begin
      return {3'b000, slot_m, 1'b0, cw_key_i, ptt_key_i, body};
    end
  endfunction

  // One clock of random stimulus, model update and checks
  task automatic run_cycle();
    logic              rd;
    logic              capture;
    logic [RESP_W-1:0] exp_resp;
    cw_key_i       = (random_bits(3) == 0);
    ptt_key_i      = (random_bits(4) == 0);
    tx_hang_i      = (random_bits(4) == 0);
    txinhibit_i    = (random_bits(3) == 0);
    run_i          = (random_bits(4) != 0);
    rxclip_i       = (random_bits(2) == 0);
    rxgoodlvl_i    = (random_bits(5) == 0);
    fwd_pwr_i      = 12'(random_bits(12));
    rev_pwr_i      = 12'(random_bits(12));
    temperature_i  = 12'(random_bits(12));
    bias_current_i = 12'(random_bits(12));
    cmd_rqst_i     = (random_bits(3) == 0);
    resp_rqst_i    = (random_bits(3) == 0);
    if (cmd_rqst_i) begin
      case (random_bits(2))
        0:       cmd_addr_i = CMD_GENERAL;
        1:       cmd_addr_i = CMD_TX_CFG;
        2:       cmd_addr_i = CMD_CW_HANG;
        default: cmd_addr_i = 6'(random_bits(6));
      endcase
      cmd_data_i          = random_bits(32);
      cmd_ptt_i           = lfsr_bit();
      cmd_requires_resp_i = lfsr_bit();
    end

    rd       = resp_rqst_i;
    exp_resp = expected_resp();
    // One echo deep, replaced only together with a read
    capture  = cmd_rqst_i & cmd_requires_resp_i & (~pend_m | rd);
    if (capture) begin
      echo_addr_m = cmd_addr_i;
      echo_data_m = cmd_data_i;
    end
    pend_m = capture | (pend_m & ~rd);
    if (cmd_rqst_i) begin
      int_ptt_m = cmd_ptt_i;
      if (cmd_addr_i == CMD_GENERAL) begin
        sync_dis_m = cmd_data_i[12];
      end
      if (cmd_addr_i == CMD_TX_CFG) begin
        vna_m   = cmd_data_i[23];
        pa_en_m = cmd_data_i[19];
      end
      if (cmd_addr_i == CMD_CW_HANG) begin
        hang_m = {cmd_data_i[31:24], cmd_data_i[17:16]};
      end
    end
    if (rd) begin
      slot_m = slot_m + 2'd1;
      clip_m = 2'd0;
    end else if (clip_m != 2'd3) begin
      clip_m = clip_m + {1'b0, rxclip_i};
    end

    @(posedge clk);
    #2;
    if (rd) begin
      assert (resp_o === exp_resp) else begin
        resp_errs++;
        $display("error %0d ns: resp_o %h, expected %h", $time, resp_o, exp_resp);
      end
    end
    assert (rfsw_sel_o === (~vna_m & pa_en_m)) else begin
      cfg_errs++;
      $display("error %0d ns: rfsw_sel_o %b, expected %b", $time, rfsw_sel_o,
               ~vna_m & pa_en_m);
    end
    assert (disable_syncfreq_o === sync_dis_m && cw_hang_time_o === hang_m) else begin
      cfg_errs++;
      $display("error %0d ns: sync disable %b hang %h, expected %b %h", $time,
               disable_syncfreq_o, cw_hang_time_o, sync_dis_m, hang_m);
    end
  endtask

  initial begin
    clk                 = 1'b0;
    reset_i             = 1'b1;
    cmd_rqst_i          = 1'b0;
    cmd_addr_i          = '0;
    cmd_data_i          = '0;
    cmd_ptt_i           = 1'b0;
    cmd_requires_resp_i = 1'b0;
    resp_rqst_i         = 1'b0;
    cw_key_i            = 1'b0;
    ptt_key_i           = 1'b0;
    tx_hang_i           = 1'b0;
    txinhibit_i         = 1'b0;
    run_i               = 1'b0;
    rxgoodlvl_i         = 1'b0;
    rxclip_i            = 1'b0;
    fwd_pwr_i           = '0;
    rev_pwr_i           = '0;
    temperature_i       = '0;
    bias_current_i      = '0;
    int_ptt_m           = 1'b0;
    vna_m               = 1'b0;
    pa_en_m             = 1'b0;
    sync_dis_m          = 1'b0;
    hang_m              = '0;
    slot_m              = 2'd0;
    clip_m              = 2'd0;
    pend_m              = 1'b0;
    echo_addr_m         = '0;
    echo_data_m         = '0;
    lfsr_q              = 16'd43;
    resp_errs           = 0;
    cfg_errs            = 0;

    repeat (4) @(posedge clk);
    #2;
    reset_i = 1'b0;
    assert (resp_o === {8'h00, 7'b0001111, 1'b0, 16'h0000, SERIAL} &&
            led_clip_o && led_goodlvl_o && !tx_on_o) else begin
      cfg_errs++;
      $display("error %0d ns: outputs after reset are wrong, resp_o %h", $time, resp_o);
    end

    for (int c = 0; c < STIM_CYCLES - 4; c++) begin
      run_cycle();
    end

    $display("Done: %0d response errors, %0d config errors, %0d assertion failures",
             resp_errs, cfg_errs, uut.u_props.fail_cnt);
    if (resp_errs + cfg_errs + uut.u_props.fail_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Run timed out after %0d ns before the stimulus finished", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* list.f */
logic/radio_ctrl_pkg.sv
logic/tick_timer.sv
logic/led_flash.sv
logic/cmd_regs.sv
logic/tx_keying.sv
logic/resp_fsm.sv
logic/radio_ctrl_top.sv
testbench/radio_ctrl_props.sv
testbench/radio_ctrl_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert -f list.f --top-module radio_ctrl_tb -Mdir obj_dir -o radio_ctrl_sim
	./obj_dir/radio_ctrl_sim | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
